/* hw/sa_ctrl_pkg.sv */
package sa_ctrl_pkg;

        // ===================================================================
        // widths and clock rates
        // ===================================================================
        localparam int TB_W   = 5;
        localparam int CNT_W  = 24;
        localparam int SEQ_W  = 8;
        localparam int MODE_W = 2;
        localparam int ST_W   = 2;

        localparam int ADC_F         = 200_000_000;
        localparam int REAL_F_MIN    = 40;                     // slowest real-time rate in Hz.
        localparam int EQUI_F_MAX    = 1_000_000;              // equivalent-time point rate in Hz.
        localparam int REAL_DIV_BASE = ADC_F / REAL_F_MIN;
        localparam int EQUI_DIV      = ADC_F / EQUI_F_MAX;

        // ===================================================================
        // mode and sequencer state codes
        // ===================================================================
        localparam logic [MODE_W-1:0] MODE_OFF  = 2'd0;
        localparam logic [MODE_W-1:0] MODE_REAL = 2'd1;
        localparam logic [MODE_W-1:0] MODE_EQUI = 2'd2;

        localparam logic [ST_W-1:0] ST_ARMED  = 2'd0;   // waiting for a trigger.
        localparam logic [ST_W-1:0] ST_DELAY  = 2'd1;   // round offset is running.
        localparam logic [ST_W-1:0] ST_SAMPLE = 2'd2;   // points are being emitted.

        // ===================================================================
        // timebase codes, real-time up to 20 us and equivalent-time below
        // ===================================================================
        localparam logic [TB_W-1:0] TIME_500MS = 5'd0;
        localparam logic [TB_W-1:0] TIME_200MS = 5'd1;
        localparam logic [TB_W-1:0] TIME_100MS = 5'd2;
        localparam logic [TB_W-1:0] TIME_50MS  = 5'd3;
        localparam logic [TB_W-1:0] TIME_20MS  = 5'd4;
        localparam logic [TB_W-1:0] TIME_10MS  = 5'd5;
        localparam logic [TB_W-1:0] TIME_5MS   = 5'd6;
        localparam logic [TB_W-1:0] TIME_2MS   = 5'd7;
        localparam logic [TB_W-1:0] TIME_1MS   = 5'd8;
        localparam logic [TB_W-1:0] TIME_500US = 5'd9;
        localparam logic [TB_W-1:0] TIME_200US = 5'd10;
        localparam logic [TB_W-1:0] TIME_100US = 5'd11;
        localparam logic [TB_W-1:0] TIME_50US  = 5'd12;
        localparam logic [TB_W-1:0] TIME_20US  = 5'd13;
        localparam logic [TB_W-1:0] TIME_10US  = 5'd14;
        localparam logic [TB_W-1:0] TIME_5US   = 5'd15;
        localparam logic [TB_W-1:0] TIME_2US   = 5'd16;
        localparam logic [TB_W-1:0] TIME_1US   = 5'd17;
        localparam logic [TB_W-1:0] TIME_500NS = 5'd18;
        localparam logic [TB_W-1:0] TIME_200NS = 5'd19;
        localparam logic [TB_W-1:0] TIME_100NS = 5'd20;

        // decoded sampling setting, unused fields stay zero.
        typedef struct packed {
                logic [MODE_W-1:0] mode;
                logic [CNT_W-1:0]  real_div;     // real-time period in clocks.
                logic [SEQ_W-1:0]  round_max;    // rounds per sweep.
                logic [SEQ_W-1:0]  point_max;    // points per round.
                logic [CNT_W-1:0]  round_step;   // extra delay per round in clocks.
        } sa_cfg_t;

endpackage

/* hw/sa_timebase_decode.sv */
`timescale 1ns/1ps

module sa_timebase_decode (
        input  logic                         ADC_clk,
        input  logic                         sys_rst_n,
        input  logic [sa_ctrl_pkg::TB_W-1:0] time_state,
        output sa_ctrl_pkg::sa_cfg_t         cfg,
        output logic                         restart
);
        import sa_ctrl_pkg::*;

        logic [TB_W-1:0] ts_q;       // sampled timebase code.
        logic [TB_W-1:0] ts_prev;    // code of the previous cycle.
        sa_cfg_t         cfg_nxt;

        function automatic sa_cfg_t real_cfg(input int div);
                sa_cfg_t c;
                c          = '0;
                c.mode     = MODE_REAL;
                c.real_div = CNT_W'(div);
                return c;
        endfunction

        function automatic sa_cfg_t equi_cfg(input int rounds, input int points);
                sa_cfg_t c;
                c            = '0;
                c.mode       = MODE_EQUI;
                c.round_max  = SEQ_W'(rounds);
                c.point_max  = SEQ_W'(points);
                c.round_step = CNT_W'(EQUI_DIV / rounds);
                return c;
        endfunction

        // ===================================================================
        // timebase lookup
        // ===================================================================
        always_comb begin
                cfg_nxt = '0;
                case (ts_q)
                TIME_500MS: cfg_nxt = real_cfg(REAL_DIV_BASE);
                TIME_200MS: cfg_nxt = real_cfg(REAL_DIV_BASE * 2 / 5);  // divide by 2.5.
                TIME_100MS: cfg_nxt = real_cfg(REAL_DIV_BASE / 5);
                TIME_50MS:  cfg_nxt = real_cfg(REAL_DIV_BASE / 10);
                TIME_20MS:  cfg_nxt = real_cfg(REAL_DIV_BASE / 25);
                TIME_10MS:  cfg_nxt = real_cfg(REAL_DIV_BASE / 50);
                TIME_5MS:   cfg_nxt = real_cfg(REAL_DIV_BASE / 100);
                TIME_2MS:   cfg_nxt = real_cfg(REAL_DIV_BASE / 250);
                TIME_1MS:   cfg_nxt = real_cfg(REAL_DIV_BASE / 500);
                TIME_500US: cfg_nxt = real_cfg(REAL_DIV_BASE / 1000);
                TIME_200US: cfg_nxt = real_cfg(REAL_DIV_BASE / 2500);
                TIME_100US: cfg_nxt = real_cfg(REAL_DIV_BASE / 5000);
                TIME_50US:  cfg_nxt = real_cfg(REAL_DIV_BASE / 10000);
                TIME_20US:  cfg_nxt = real_cfg(REAL_DIV_BASE / 25000);
                TIME_10US:  cfg_nxt = equi_cfg(2, 200);
                TIME_5US:   cfg_nxt = equi_cfg(4, 100);
                TIME_2US:   cfg_nxt = equi_cfg(10, 40);
                TIME_1US:   cfg_nxt = equi_cfg(20, 20);
                TIME_500NS: cfg_nxt = equi_cfg(40, 10);
                TIME_200NS: cfg_nxt = equi_cfg(100, 4);
                TIME_100NS: cfg_nxt = equi_cfg(200, 2);
                default: begin
                        cfg_nxt      = '0;
                        cfg_nxt.mode = MODE_OFF;                // codes 21 to 31 switch both engines off.
                end
                endcase
        end

        // ===================================================================
        // code register and change detect
        // ===================================================================
        always_ff @(posedge ADC_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        ts_q    <= '0;
                        ts_prev <= '0;
                        restart <= 1'b0;
                        cfg     <= '0;
                end else begin
                        ts_q    <= time_state;
                        ts_prev <= ts_q;
                        restart <= (ts_q != ts_prev);           // lands together with the new cfg.
                        cfg     <= cfg_nxt;
                end
        end

        // a single code change gives a single restart pulse.
        a_restart_single: assert property (@(posedge ADC_clk) disable iff (!sys_rst_n)
                (restart && $stable(ts_q)) |=> !restart)
                else $error("restart held for two cycles on a stable code");

endmodule

/* hw/sa_realtime_divider.sv */
`timescale 1ns/1ps

module sa_realtime_divider (
        input  logic                 ADC_clk,
        input  logic                 sys_rst_n,
        input  sa_ctrl_pkg::sa_cfg_t cfg,
        input  logic                 restart,
        output logic                 rt_pulse
);
        import sa_ctrl_pkg::*;

        logic [CNT_W-1:0] div_cnt;
        logic             real_on;
        logic             div_wrap;

        assign real_on  = (cfg.mode == MODE_REAL);
        assign div_wrap = (div_cnt >= cfg.real_div - 1'b1);     // last clock of the period.

        // ===================================================================
        // period counter
        // ===================================================================
        always_ff @(posedge ADC_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        div_cnt  <= '0;
                        rt_pulse <= 1'b0;
                end else if (restart || !real_on) begin
                        div_cnt  <= '0;                         // idle and in phase zero.
                        rt_pulse <= 1'b0;
                end else if (div_wrap) begin
                        div_cnt  <= '0;
                        rt_pulse <= 1'b1;
                end else begin
                        div_cnt  <= div_cnt + 1'b1;
                        rt_pulse <= 1'b0;
                end
        end

        // the decoder never hands out a period shorter than two clocks.
        a_rt_pulse_single: assert property (@(posedge ADC_clk) disable iff (!sys_rst_n)
                rt_pulse |=> !rt_pulse)
                else $error("real-time pulse high in two consecutive cycles");

endmodule

/* hw/sa_equi_sequencer.sv */
`timescale 1ns/1ps

module sa_equi_sequencer (
        input  logic                 ADC_clk,
        input  logic                 sys_rst_n,
        input  sa_ctrl_pkg::sa_cfg_t cfg,
        input  logic                 restart,
        input  logic                 trig_flag,
        output logic                 eq_pulse,
        output logic                 equi_flag
);
        import sa_ctrl_pkg::*;

        logic [ST_W-1:0]  state;
        logic [CNT_W-1:0] dly_cnt;     // remaining round offset.
        logic [CNT_W-1:0] sp_cnt;      // clocks since the last point.
        logic [SEQ_W-1:0] pt_cnt;      // points emitted in this round.
        logic [SEQ_W-1:0] round_idx;
        logic             equi_on;
        logic             sp_wrap;
        logic             last_pt;
        logic             last_round;

        assign equi_on    = (cfg.mode == MODE_EQUI);
        assign sp_wrap    = (sp_cnt == CNT_W'(EQUI_DIV - 1));
        assign last_pt    = (pt_cnt == cfg.point_max);
        assign last_round = (round_idx == cfg.round_max - 1'b1);

        // ===================================================================
        // round sequencing
        // ===================================================================
        always_ff @(posedge ADC_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        state     <= ST_ARMED;
                        dly_cnt   <= '0;
                        sp_cnt    <= '0;
                        pt_cnt    <= '0;
                        round_idx <= '0;
                        eq_pulse  <= 1'b0;
                        equi_flag <= 1'b0;
                end else if (restart || !equi_on) begin
                        state     <= ST_ARMED;                  // a new timebase starts at round 0.
                        dly_cnt   <= '0;
                        sp_cnt    <= '0;
                        pt_cnt    <= '0;
                        round_idx <= '0;
                        eq_pulse  <= 1'b0;
                        equi_flag <= 1'b0;
                end else begin
                        eq_pulse  <= 1'b0;
                        equi_flag <= 1'b0;
                        case (state)
                        ST_ARMED: begin
                                if (trig_flag) begin
                                        dly_cnt <= round_idx * cfg.round_step;
                                        state   <= ST_DELAY;
                                end
                        end
                        ST_DELAY: begin
                                if (dly_cnt == '0) begin
                                        eq_pulse <= 1'b1;               // first point of the round.
                                        sp_cnt   <= '0;
                                        pt_cnt   <= SEQ_W'(1);
                                        state    <= ST_SAMPLE;
                                end else begin
                                        dly_cnt <= dly_cnt - 1'b1;
                                end
                        end
                        ST_SAMPLE: begin
                                if (!sp_wrap) begin
                                        sp_cnt <= sp_cnt + 1'b1;
                                end else if (!last_pt) begin
                                        eq_pulse <= 1'b1;
                                        sp_cnt   <= '0;
                                        pt_cnt   <= pt_cnt + 1'b1;
                                end else begin
                                        // one spacing after the last point the round is over.
                                        sp_cnt <= '0;
                                        pt_cnt <= '0;
                                        state  <= ST_ARMED;
                                        if (last_round) begin
                                                equi_flag <= 1'b1;      // sweep complete.
                                                round_idx <= '0;
                                        end else begin
                                                round_idx <= round_idx + 1'b1;
                                        end
                                end
                        end
                        default: begin
                                state <= ST_ARMED;
                        end
                        endcase
                end
        end

        // ===================================================================
        // checks
        // ===================================================================
        a_flag_single: assert property (@(posedge ADC_clk) disable iff (!sys_rst_n)
                equi_flag |=> !equi_flag)
                else $error("equi_flag longer than one cycle");

        a_round_range: assert property (@(posedge ADC_clk) disable iff (!sys_rst_n)
                (equi_on && !restart) |-> (round_idx < cfg.round_max))
                else $error("round index reached round_max");

        a_pulse_in_sample: assert property (@(posedge ADC_clk) disable iff (!sys_rst_n)
                eq_pulse |-> (state == ST_SAMPLE))
                else $error("equivalent pulse outside the sampling state");

endmodule

/* hw/sa_clk_gen.sv */
`timescale 1ns/1ps

module sa_clk_gen (
        input  logic                         ADC_clk,
        input  logic                         sys_rst_n,
        input  logic [sa_ctrl_pkg::TB_W-1:0] time_state,
        input  logic                         trig_flag,
        output logic                         sa_clk,
        output logic                         equi_flag
);
        import sa_ctrl_pkg::*;

        sa_cfg_t cfg;
        logic    restart;
        logic    rt_pulse;
        logic    eq_pulse;

        // ===================================================================
        // decoder and the two sampling engines
        // ===================================================================
        sa_timebase_decode i_sa_timebase_decode (
                .ADC_clk    (ADC_clk),
                .sys_rst_n  (sys_rst_n),
                .time_state (time_state),
                .cfg        (cfg),
                .restart    (restart)
        );

        sa_realtime_divider i_sa_realtime_divider (
                .ADC_clk   (ADC_clk),
                .sys_rst_n (sys_rst_n),
                .cfg       (cfg),
                .restart   (restart),
                .rt_pulse  (rt_pulse)
        );

        sa_equi_sequencer i_sa_equi_sequencer (
                .ADC_clk   (ADC_clk),
                .sys_rst_n (sys_rst_n),
                .cfg       (cfg),
                .restart   (restart),
                .trig_flag (trig_flag),
                .eq_pulse  (eq_pulse),
                .equi_flag (equi_flag)
        );

        assign sa_clk = rt_pulse | eq_pulse;                    // only one engine runs at a time.

        a_engines_exclusive: assert property (@(posedge ADC_clk) disable iff (!sys_rst_n)
                !(rt_pulse && eq_pulse))
                else $error("both sampling engines pulsed in the same cycle");

endmodule

/* sim/tb_sa_clk_gen.sv */
`timescale 1ns/1ps

module tb_sa_clk_gen;
        import sa_ctrl_pkg::*;

        // ======================================================================
        // clock, reset and run limits
        // ======================================================================
        localparam int CLK_PERIOD    = 100;
        localparam int RESET_CYCLES  = 8;
        localparam int SETTLE_CYCLES = 4;      // code change to restart and new cfg.
        localparam int OFF_CYCLES    = 1_000;
        localparam int BUDGET_OFF    = 2_000;
        localparam int BUDGET_REAL   = 10_000;
        localparam int BUDGET_SWEEP  = 140_000;
        localparam int BUDGET_IGNORE = 100_000;
        localparam int BUDGET_CHANGE = 148_000;
        localparam int WATCHDOG_CYCLES =
                (BUDGET_OFF + BUDGET_REAL + BUDGET_SWEEP + BUDGET_IGNORE + BUDGET_CHANGE) * 11 / 10;

        logic            ADC_clk;
        logic            sys_rst_n;
        logic [TB_W-1:0] time_state;
        logic            trig_flag;
        logic            sa_clk;
        logic            equi_flag;

        int mismatches;
        int failures;
        int checks;
        int rng_init;

        sa_clk_gen i_sa_clk_gen (
                .ADC_clk    (ADC_clk),
                .sys_rst_n  (sys_rst_n),
                .time_state (time_state),
                .trig_flag  (trig_flag),
                .sa_clk     (sa_clk),
                .equi_flag  (equi_flag)
        );

        initial begin
                ADC_clk = 1'b0;
                forever #(CLK_PERIOD / 2) ADC_clk = ~ADC_clk;
        end

        // ======================================================================
        // helpers and compare tasks
        // ======================================================================
        task automatic next_cycle();
                @(posedge ADC_clk);
                #1;                                     // outputs settled, inputs may change.
        endtask

        task automatic report_failure(input string msg);
                failures++;
                $display("Error at %0t ns: %s", $time, msg);
        endtask

        task automatic compare_interval(input logic [CNT_W-1:0] got,
                                        input logic [CNT_W-1:0] exp, input string what);
                checks++;
                if (got !== exp) begin
                        mismatches++;
                        $display("Mismatch at %0t ns: %s, got %0d, expected %0d",
                                 $time, what, got, exp);
                end
        endtask

        task automatic compare_count(input logic [SEQ_W-1:0] got,
                                     input logic [SEQ_W-1:0] exp, input string what);
                checks++;
                if (got !== exp) begin
                        mismatches++;
                        $display("Mismatch at %0t ns: %s, got %0d, expected %0d",
                                 $time, what, got, exp);
                end
        endtask

        task automatic compare_level(input logic got, input logic exp, input string what);
                checks++;
                if (got !== exp) begin
                        mismatches++;
                        $display("Mismatch at %0t ns: %s, got %b, expected %b",
                                 $time, what, got, exp);
                end
        endtask

        task automatic set_timebase(input logic [TB_W-1:0] code);
                time_state = code;
                trig_flag  = 1'b0;
                repeat (SETTLE_CYCLES) next_cycle();
        endtask

        // counts clocks up to the next sample pulse, optionally with stray triggers.
        task automatic wait_for_pulse(input int limit, input bit noisy,
                                      output int n, output bit found);
                n     = 0;
                found = 1'b0;
                while (!found && n < limit) begin
                        next_cycle();
                        n++;
                        if (equi_flag)
                                report_failure("equi_flag rose while a sample pulse was pending");
                        if (sa_clk)
                                found = 1'b1;
                        else if (noisy)
                                trig_flag = ($urandom_range(0, 3) == 0);
                end
                trig_flag = 1'b0;
        endtask

        task automatic run_round(input int r, input int step, input int points,
                                 input bit last, input bit noisy);
                int gap;
                int n;
                int since;
                int pulses;
                int span;
                bit found;
                gap = $urandom_range(1, 50);
                repeat (gap) begin
                        next_cycle();
                        if (sa_clk || equi_flag)
                                report_failure("output pulse while armed for a trigger");
                end
                trig_flag = 1'b1;
                next_cycle();                           // this edge samples the trigger.
                trig_flag = 1'b0;
                wait_for_pulse(r * step + 20, noisy, n, found);
                if (!found) begin
                        report_failure($sformatf("round %0d never produced a sample pulse", r));
                        return;
                end
                compare_interval(CNT_W'(n), CNT_W'(r * step + 1),
                                 $sformatf("round %0d trigger to first sample", r));
                pulses = 1;
                since  = 0;
                span   = points * EQUI_DIV;             // last point plus one spacing.
                for (int i = 1; i <= span; i++) begin
                        next_cycle();
                        since++;
                        if (sa_clk) begin
                                pulses++;
                                compare_interval(CNT_W'(since), CNT_W'(EQUI_DIV),
                                                 $sformatf("round %0d sample spacing", r));
                                since = 0;
                        end
                        compare_level(equi_flag, (i == span) && last,
                                      $sformatf("round %0d equi_flag", r));
                        if (noisy && i < span)
                                trig_flag = ($urandom_range(0, 3) == 0);
                        else
                                trig_flag = 1'b0;
                end
                compare_count(SEQ_W'(pulses), SEQ_W'(points),
                              $sformatf("round %0d sample count", r));
        endtask

        task automatic check_real_period(input logic [TB_W-1:0] code, input int period);
                int n;
                bit found;
                set_timebase(code);
                wait_for_pulse(2 * period, 1'b0, n, found);     // phase after restart is free.
                if (!found)
                        report_failure("real-time divider gave no first pulse");
                repeat (5) begin
                        wait_for_pulse(2 * period, 1'b0, n, found);
                        if (!found)
                                report_failure("real-time divider stopped pulsing");
                        else
                                compare_interval(CNT_W'(n), CNT_W'(period), "real-time interval");
                end
        endtask

        // ======================================================================
        // directed tests
        // ======================================================================
        task automatic test_reset_and_off();
                for (int i = 0; i < RESET_CYCLES; i++) begin
                        next_cycle();
                        compare_level(sa_clk, 1'b0, "sa_clk in reset");
                        compare_level(equi_flag, 1'b0, "equi_flag in reset");
                end
                sys_rst_n = 1'b1;
                repeat (OFF_CYCLES) begin
                        next_cycle();
                        trig_flag = ($urandom_range(0, 1) == 1);    // triggers must do nothing here.
                        compare_level(sa_clk, 1'b0, "sa_clk with an undefined code");
                        compare_level(equi_flag, 1'b0, "equi_flag with an undefined code");
                end
                trig_flag = 1'b0;
        endtask

        task automatic test_realtime();
                check_real_period(TIME_20US, 200);
                check_real_period(TIME_50US, 500);
        endtask

        task automatic test_sweep_100ns();
                set_timebase(TIME_100NS);
                for (int r = 0; r < 200; r++)
                        run_round(r, 1, 2, r == 199, 1'b0);
        endtask

        task automatic test_ignored_triggers();
                set_timebase(TIME_500NS);
                for (int r = 0; r < 40; r++)
                        run_round(r, 5, 10, r == 39, 1'b1);
        endtask

        task automatic test_change_mid_sweep();
                set_timebase(TIME_1US);
                for (int r = 0; r < 7; r++)
                        run_round(r, 10, 20, 1'b0, 1'b0);
                set_timebase(TIME_200NS);                       // the sweep starts over at round 0.
                for (int r = 0; r < 100; r++)
                        run_round(r, 2, 4, r == 99, 1'b0);
        endtask

        // ======================================================================
        // sequence and watchdog
        // ======================================================================
        initial begin
                sys_rst_n  = 1'b0;
                time_state = 5'd31;
                trig_flag  = 1'b0;
                mismatches = 0;
                failures   = 0;
                checks     = 0;
                rng_init   = $urandom(43);
                test_reset_and_off();
                test_realtime();
                test_sweep_100ns();
                test_ignored_triggers();
                test_change_mid_sweep();
                $display("checks: %0d, mismatches: %0d, other failures: %0d",
                         checks, mismatches, failures);
                if (mismatches + failures == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge ADC_clk);
                $display("Watchdog expired after %0d cycles, the tests did not finish",
                         WATCHDOG_CYCLES);
                $display("TEST FAILED");
                $finish;
        end

endmodule

/* sa_clk_gen.f */
hw/sa_ctrl_pkg.sv
hw/sa_timebase_decode.sv
hw/sa_realtime_divider.sv
hw/sa_equi_sequencer.sv
hw/sa_clk_gen.sv
sim/tb_sa_clk_gen.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the sample-clock testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sa_clk_gen.f --top-module tb_sa_clk_gen -o tb_sa_clk_gen
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed with status $status"
        exit 1
fi

./obj_dir/tb_sa_clk_gen > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "^TEST OK$" sim.log; then
        echo "simulation passed"
        exit 0
fi

echo "simulation did not pass, see sim.log"
exit 1
